/* lcd_timing_pkg.sv */
package lcd_timing_pkg;

	localparam int cycles_per_us = 5; // fixed clock rate

	// 12 bits hold the longest delay, the power-up wait
	typedef logic [11:0] count_t;

	// power-up and initialization
	localparam count_t power_up_cycles = count_t'(500 * cycles_per_us); // 500 us
	localparam count_t instr_pulse_cycles = count_t'(10 * cycles_per_us); // e high per instr
	localparam count_t short_wait_cycles = count_t'(50 * cycles_per_us); // func set, display ctrl
	localparam count_t clear_wait_cycles = count_t'(200 * cycles_per_us); // after clear
	localparam count_t entry_wait_cycles = count_t'(100 * cycles_per_us); // after entry mode

	// single bus write
	localparam count_t write_setup_cycles = count_t'(1 * cycles_per_us); // e low before pulse
	localparam count_t write_high_cycles = count_t'(13 * cycles_per_us); // e high
	localparam count_t write_low_cycles = count_t'(13 * cycles_per_us); // e low after pulse
	localparam count_t write_total_cycles = count_t'(50 * cycles_per_us); // whole write

endpackage

/* lcd_cmd_pkg.sv */
package lcd_cmd_pkg;

	typedef logic [7:0] byte_t;

	// same bit order as the 7-bit config input, two_line is bit 6
	typedef struct packed {
		logic two_line;
		logic font_5x10;
		logic display_on;
		logic cursor_on;
		logic blink_on;
		logic increment;
		logic shift;
	} lcd_config_t;

	// write request word, rs is bit 9
	typedef struct packed {
		logic  rs;
		logic  rw;
		byte_t data;
	} lcd_bus_t;

	// panel pins
	typedef struct packed {
		logic  e;
		logic  rs;
		logic  rw;
		byte_t data;
	} lcd_pins_t;

	// fixed high bits of the init instructions
	localparam logic [3:0] op_function_set = 4'b0011; // 8-bit bus
	localparam logic [4:0] op_display_ctrl = 5'b00001;
	localparam byte_t op_clear = 8'b0000_0001;
	localparam logic [5:0] op_entry_mode = 6'b000001;

endpackage

/* lcd_init_seq.sv */
module lcd_init_seq (
	input  logic                      clk,
	input  logic                      reset,
	input  lcd_cmd_pkg::lcd_config_t  cfg,
	output lcd_cmd_pkg::lcd_pins_t    init_pins,
	output logic                      init_done
);
	import lcd_timing_pkg::*;
	import lcd_cmd_pkg::*;

	typedef enum logic [3:0] {
		power_up,
		function_set,
		func_wait,
		display_ctrl,
		ctrl_wait,
		clear,
		clear_wait,
		entry_mode,
		entry_wait,
		done
	} state_t;

	state_t      state;
	state_t      next_state;
	count_t      count; // shared by all states
	count_t      state_len;
	logic        last;
	lcd_config_t cfg_q;
	byte_t       instr_data;

	always_comb begin
		state_len = '0;
		next_state = state;
		case (state)
			power_up: begin
				state_len = power_up_cycles;
				next_state = function_set;
			end
			function_set: begin
				state_len = instr_pulse_cycles;
				next_state = func_wait;
			end
			func_wait: begin
				state_len = short_wait_cycles;
				next_state = display_ctrl;
			end
			display_ctrl: begin
				state_len = instr_pulse_cycles;
				next_state = ctrl_wait;
			end
			ctrl_wait: begin
				state_len = short_wait_cycles;
				next_state = clear;
			end
			clear: begin
				state_len = instr_pulse_cycles;
				next_state = clear_wait;
			end
			clear_wait: begin
				state_len = clear_wait_cycles;
				next_state = entry_mode;
			end
			entry_mode: begin
				state_len = instr_pulse_cycles;
				next_state = entry_wait;
			end
			entry_wait: begin
				state_len = entry_wait_cycles;
				next_state = done;
			end
			default: ; // done holds
		endcase
	end

	assign last = (count == state_len - 1'b1);

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= power_up;
			count <= '0;
		end else if (state != done) begin
			if (last) begin
				state <= next_state;
				count <= '0;
			end else begin
				count <= count + 1'b1;
			end
		end
	end

	// config held from end of power-up onward
	always_ff @(posedge clk) begin
		if (state == power_up && last)
			cfg_q <= cfg;
	end

	always_comb begin
		instr_data = '0;
		case (state)
			function_set: instr_data = {op_function_set, cfg_q.two_line, cfg_q.font_5x10, 2'b00};
			display_ctrl: instr_data = {op_display_ctrl, cfg_q.display_on, cfg_q.cursor_on,
				cfg_q.blink_on};
			clear:        instr_data = op_clear;
			entry_mode:   instr_data = {op_entry_mode, cfg_q.increment, cfg_q.shift};
			default:      instr_data = '0; // waits drive zero
		endcase
	end

	// e only in the instruction states, rs and rw always low
	assign init_pins = '{
		e:    (state == function_set) || (state == display_ctrl) ||
		      (state == clear) || (state == entry_mode),
		rs:   1'b0,
		rw:   1'b0,
		data: instr_data
	};

	assign init_done = (state == done);

endmodule

/* lcd_write_seq.sv */
module lcd_write_seq (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    wr_start,
	input  lcd_cmd_pkg::lcd_bus_t   wr_req,
	output lcd_cmd_pkg::lcd_pins_t  wr_pins,
	output logic                    wr_active
);
	import lcd_timing_pkg::*;
	import lcd_cmd_pkg::*;

	typedef enum logic {
		idle,
		cycle
	} state_t;

	state_t   state;
	count_t   count;
	lcd_bus_t req_q; // word held for the whole write
	logic     e_high;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= idle;
			count <= '0;
		end else begin
			case (state)
				idle: begin
					if (wr_start) begin
						state <= cycle;
						count <= '0;
					end
				end
				cycle: begin
					if (count == write_total_cycles - 1'b1) // end of write
						state <= idle;
					else
						count <= count + 1'b1;
				end
				default: state <= idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == idle && wr_start)
			req_q <= wr_req;
	end

	// setup phase, then the high phase, low for the remainder
	assign e_high = (count >= write_setup_cycles) &&
		(count < write_setup_cycles + write_high_cycles);

	assign wr_active = (state == cycle);

	always_comb begin
		wr_pins = '0;
		if (state == cycle) begin
			wr_pins.e = e_high;
			wr_pins.rs = req_q.rs;
			wr_pins.rw = req_q.rw; // rw high driven only, no readback
			wr_pins.data = req_q.data;
		end
	end

endmodule

/* lcd_pin_arbiter.sv */
module lcd_pin_arbiter (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    wr_strobe,
	input  lcd_cmd_pkg::lcd_bus_t   wr_word,
	input  logic                    init_done,
	input  logic                    wr_active,
	input  lcd_cmd_pkg::lcd_pins_t  init_pins,
	input  lcd_cmd_pkg::lcd_pins_t  wr_pins,
	output logic                    wr_start,
	output lcd_cmd_pkg::lcd_bus_t   wr_req,
	output lcd_cmd_pkg::lcd_pins_t  pins,
	output logic                    busy
);
	import lcd_cmd_pkg::*;

	logic      accept;
	lcd_pins_t pins_sel;

	// strobes outside this window are dropped
	assign accept = wr_strobe && init_done && !wr_active && !wr_start;

	always_ff @(posedge clk) begin
		if (reset)
			wr_start <= 1'b0;
		else
			wr_start <= accept; // one-cycle pulse
	end

	always_ff @(posedge clk) begin
		if (accept)
			wr_req <= wr_word;
	end

	// init owns the pins until done, the write sequencer after
	assign pins_sel = init_done ? wr_pins : init_pins;

	always_ff @(posedge clk) begin
		if (reset) begin
			pins <= '0;
			busy <= 1'b1;
		end else begin
			pins <= pins_sel;
			busy <= !init_done || wr_active || wr_start || accept; // covers the start gap
		end
	end

endmodule

/* lcd_controller.sv */
module lcd_controller (
	input  logic                      clk,
	input  logic                      reset,
	input  lcd_cmd_pkg::lcd_config_t  cfg,
	input  logic                      wr_strobe,
	input  lcd_cmd_pkg::lcd_bus_t     wr_word,
	output lcd_cmd_pkg::lcd_pins_t    pins,
	output logic                      busy
);
	import lcd_cmd_pkg::*;

	lcd_pins_t init_pins;
	lcd_pins_t wr_pins;
	lcd_bus_t  wr_req;
	logic      init_done;
	logic      wr_start;
	logic      wr_active;

	lcd_init_seq u_init_seq (
		.clk       (clk),
		.reset     (reset),
		.cfg       (cfg),
		.init_pins (init_pins),
		.init_done (init_done)
	);

	lcd_write_seq u_write_seq (
		.clk       (clk),
		.reset     (reset),
		.wr_start  (wr_start),
		.wr_req    (wr_req),
		.wr_pins   (wr_pins),
		.wr_active (wr_active)
	);

	lcd_pin_arbiter u_pin_arbiter (
		.clk       (clk),
		.reset     (reset),
		.wr_strobe (wr_strobe),
		.wr_word   (wr_word),
		.init_done (init_done),
		.wr_active (wr_active),
		.init_pins (init_pins),
		.wr_pins   (wr_pins),
		.wr_start  (wr_start),
		.wr_req    (wr_req),
		.pins      (pins),
		.busy      (busy)
	);

endmodule

/* lcd_controller_tb.sv */
module lcd_controller_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import lcd_timing_pkg::*;
	import lcd_cmd_pkg::*;

	logic        clk;
	logic        reset;
	lcd_config_t cfg;
	logic        wr_strobe;
	lcd_bus_t    wr_word;
	lcd_pins_t   pins;
	logic        busy;
	integer      seed;

	lcd_controller uut (
		.clk       (clk),
		.reset     (reset),
		.cfg       (cfg),
		.wr_strobe (wr_strobe),
		.wr_word   (wr_word),
		.pins      (pins),
		.busy      (busy)
	);

	always #4 clk = ~clk; // 8 ns period

	task automatic compare(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("error: %s is %h, expected %h at %0t", name, actual, expected, $time);
			$display("Test FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic fail_timeout(input string what);
		$display("timeout: %s never came", what);
		$display("Test FAILED");
		$fatal(1, "wait timed out");
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#1; // drive and sample point
	endtask

	task automatic check_pins(input lcd_pins_t expected, input logic busy_exp);
		compare("pins.e", pins.e, expected.e);
		compare("pins.rs", pins.rs, expected.rs);
		compare("pins.rw", pins.rw, expected.rw);
		compare("pins.data", pins.data, expected.data);
		compare("busy", busy, busy_exp);
	endtask

	function automatic lcd_bus_t random_word();
		logic [31:0] r;
		r = $random(seed);
		return r[9:0];
	endfunction

	// HD44780 instruction layout, k in init order
	function automatic lcd_pins_t instr_pins(input int k, input lcd_config_t c);
		lcd_pins_t p;
		p = '0;
		p.e = 1'b1;
		case (k)
			0: begin
				p.data = {op_function_set, 4'b0000};
				p.data[3] = c.two_line; // N
				p.data[2] = c.font_5x10; // F
			end
			1: begin
				p.data = {op_display_ctrl, 3'b000};
				p.data[2] = c.display_on;
				p.data[1] = c.cursor_on;
				p.data[0] = c.blink_on;
			end
			2: p.data = op_clear;
			default: begin
				p.data = {op_entry_mode, 2'b00};
				p.data[1] = c.increment; // I/D
				p.data[0] = c.shift;
			end
		endcase
		return p;
	endfunction

	task automatic check_idle(input int n);
		repeat (n) begin
			next_cycle();
			check_pins('0, 1'b0);
		end
	endtask

	task automatic wait_idle(input int limit);
		int n;
		n = 0;
		while (busy) begin
			if (n == limit)
				fail_timeout("busy low before a write");
			else begin
				n++;
				next_cycle();
			end
		end
	endtask

	// entered in strobe cycle T, returns in T+252
	task automatic expect_write(input lcd_bus_t w, input bit intrude);
		lcd_pins_t exp;
		int        i;
		exp = '0;
		next_cycle(); // T+1
		wr_strobe = intrude; // start pending, must drop
		wr_word = random_word();
		check_pins('0, 1'b1);
		next_cycle(); // T+2
		wr_strobe = 1'b0;
		check_pins('0, 1'b1);
		exp.rs = w.rs;
		exp.rw = w.rw;
		exp.data = w.data;
		for (i = 0; i < write_total_cycles; i++) begin
			next_cycle(); // T+3+i
			// mid-write and last active cycle, must drop
			wr_strobe = intrude && (i == 100 || i == write_total_cycles - 2);
			exp.e = (i >= write_setup_cycles) && (i < write_setup_cycles + write_high_cycles);
			check_pins(exp, 1'b1);
		end
	endtask

	task automatic power_up_phase();
		int n;
		n = 0;
		repeat (4) begin
			next_cycle();
			check_pins('0, 1'b1);
		end
		reset = 1'b0;
		while (!pins.e) begin
			if (n > power_up_cycles + 10)
				fail_timeout("first init enable pulse");
			else begin
				check_pins('0, 1'b1);
				n++;
				next_cycle();
			end
		end
		compare("power-up e low cycles", n, power_up_cycles + 1); // plus pin register
	endtask

	task automatic init_sequence();
		int waits [4];
		int n;
		int k;
		waits = '{short_wait_cycles, short_wait_cycles, clear_wait_cycles, entry_wait_cycles};
		for (k = 0; k < 4; k++) begin
			n = 0;
			while (pins.e) begin
				if (n > instr_pulse_cycles)
					fail_timeout("end of init enable pulse");
				else begin
					check_pins(instr_pins(k, cfg), 1'b1);
					n++;
					next_cycle();
				end
			end
			compare("init e high cycles", n, instr_pulse_cycles);
			n = 0;
			// last wait ends with busy
			while (k < 3 ? !pins.e : busy) begin
				if (n > waits[k])
					fail_timeout("end of init wait");
				else begin
					check_pins('0, 1'b1);
					wr_strobe = (k == 3) && (n == waits[k] - 100); // init running, must drop
					n++;
					next_cycle();
				end
			end
			compare("init wait cycles", n, waits[k]);
		end
		check_pins('0, 1'b0);
	endtask

	task automatic single_write();
		lcd_bus_t w;
		w = random_word();
		wait_idle(50);
		wr_strobe = 1'b1;
		wr_word = w;
		expect_write(w, 1'b0);
		next_cycle(); // T+253
		check_pins('0, 1'b0);
	endtask

	task automatic dropped_strobes();
		lcd_bus_t w;
		w = random_word();
		wait_idle(50);
		wr_strobe = 1'b1;
		wr_word = w;
		expect_write(w, 1'b1);
		check_idle(300); // no second pulse
	endtask

	task automatic back_to_back_writes();
		lcd_bus_t w;
		wait_idle(50);
		repeat (4) begin
			w = random_word();
			wr_strobe = 1'b1; // idle, then T+252 of the previous write
			wr_word = w;
			expect_write(w, 1'b0);
		end
		check_idle(20);
	endtask

	initial begin
		logic [31:0] r;
		seed = 42;
		clk = 1'b0;
		reset = 1'b1;
		wr_strobe = 1'b0;
		wr_word = '0;
		r = $random(seed);
		cfg = r[6:0];
		power_up_phase();
		init_sequence();
		check_idle(20);
		single_write();
		dropped_strobes();
		back_to_back_writes();
		$display("Test OK");
		$finish;
	end

endmodule

/* lcd_controller.f */
lcd_timing_pkg.sv
lcd_cmd_pkg.sv
lcd_init_seq.sv
lcd_write_seq.sv
lcd_pin_arbiter.sv
lcd_controller.sv
lcd_controller_tb.sv
